// File: include/timer_consts.svh
`ifndef TIMER_CONSTS_SVH
`define TIMER_CONSTS_SVH

// number of alarm registers
`define TIMER_NUM_ALARMS 4

// top value of each time field, in bcd
`define CSEC_LIMIT 8'h99
`define SEC_LIMIT  8'h59
`define MIN_LIMIT  8'h59
`define HOUR_LIMIT 8'h23

`endif

// File: src/timer_pkg.sv
package timer_pkg;

    typedef logic [7:0] bcd_pair_t;   // tens digit in [7:4], units in [3:0]
    typedef logic [1:0] field_sel_t;  // 0 csec, 1 sec, 2 min, 3 hour
    typedef logic [1:0] alarm_idx_t;

    typedef enum logic [1:0] {
        MODE_CLOCK     = 2'b00,
        MODE_COUNTDOWN = 2'b01,
        MODE_STOPWATCH = 2'b10,
        MODE_ALARM_SET = 2'b11
    } timer_mode_e;

    typedef enum logic {
        RUN_STOPPED  = 1'b0,
        RUN_COUNTING = 1'b1
    } run_state_e;

    typedef struct packed {
        bcd_pair_t hour;
        bcd_pair_t min;
        bcd_pair_t sec;
        bcd_pair_t csec;
    } time_t;

    typedef struct packed {
        logic       valid;
        field_sel_t field;
        bcd_pair_t  value;
    } time_load_t;

    typedef struct packed {
        logic       valid;
        alarm_idx_t slot;
        field_sel_t field;
        bcd_pair_t  value;
    } alarm_wr_t;

endpackage

// File: src/bcd_counter.sv
`timescale 1ns/1ns

module bcd_counter #(
    parameter timer_pkg::bcd_pair_t TOP_VALUE = 8'h99
) (
    input  logic                 clk_100Hz,
    input  logic                 rst,
    input  logic                 load,
    input  timer_pkg::bcd_pair_t load_value,
    input  logic                 en,
    input  logic                 count_down,
    output timer_pkg::bcd_pair_t value,
    output logic                 carry
);
    import timer_pkg::*;

    logic      at_wrap;
    bcd_pair_t next_up;
    bcd_pair_t next_down;

    assign at_wrap = count_down ? (value == 8'h00) : (value == TOP_VALUE);
    assign carry   = en && at_wrap;   // combinational, feeds next stage enable

    always_comb begin
        if (value == TOP_VALUE) begin
            next_up = 8'h00;
        end else if (value[3:0] == 4'd9) begin
            next_up = {value[7:4] + 4'd1, 4'd0};   // units roll into tens
        end else begin
            next_up = {value[7:4], value[3:0] + 4'd1};
        end
    end

    always_comb begin
        if (value == 8'h00) begin
            next_down = TOP_VALUE;
        end else if (value[3:0] == 4'd0) begin
            next_down = {value[7:4] - 4'd1, 4'd9};   // borrow from tens
        end else begin
            next_down = {value[7:4], value[3:0] - 4'd1};
        end
    end

    always_ff @(posedge clk_100Hz) begin
        if (rst) begin
            value <= 8'h00;
        end else if (load) begin   // load wins over counting
            value <= load_value;
        end else if (en) begin
            value <= count_down ? next_down : next_up;
        end
    end

endmodule

// File: src/alarm_slot.sv
`timescale 1ns/1ns

module alarm_slot #(
    parameter timer_pkg::alarm_idx_t SLOT_INDEX = 2'd0
) (
    input  logic                 clk_100Hz,
    input  logic                 rst,
    input  timer_pkg::alarm_wr_t alarm_wr,
    input  timer_pkg::time_t     cur_time,
    output logic                 match
);
    import timer_pkg::*;

    time_t alarm_time;
    logic  armed;
    logic  wr_hit;

    assign wr_hit = alarm_wr.valid && (alarm_wr.slot == SLOT_INDEX);

    always_ff @(posedge clk_100Hz) begin
        if (rst) begin
            alarm_time <= '0;
            armed      <= 1'b0;
        end else if (wr_hit) begin
            armed <= 1'b1;
            case (alarm_wr.field)
                2'd0:    alarm_time.csec <= alarm_wr.value;
                2'd1:    alarm_time.sec  <= alarm_wr.value;
                2'd2:    alarm_time.min  <= alarm_wr.value;
                default: alarm_time.hour <= alarm_wr.value;
            endcase
        end
    end

    assign match = armed && (alarm_time == cur_time);   // all four fields

endmodule

// File: src/setup_control.sv
`timescale 1ns/1ns

module setup_control (
    input  logic                   clk_100Hz,
    input  logic                   rst,
    input  logic                   start_pause,
    input  logic                   read_para,
    input  timer_pkg::timer_mode_e mode,
    input  timer_pkg::field_sel_t  para_select,
    input  timer_pkg::alarm_idx_t  alarm_no,
    input  timer_pkg::bcd_pair_t   data_bcd,
    output timer_pkg::run_state_e  running,
    output timer_pkg::time_load_t  time_load,
    output timer_pkg::alarm_wr_t   alarm_wr
);
    import timer_pkg::*;

    logic alarm_mode;

    assign alarm_mode = (mode == MODE_ALARM_SET);

    // run/stop fsm
    always_ff @(posedge clk_100Hz) begin
        if (rst) begin
            running <= RUN_STOPPED;
        end else if (read_para || alarm_mode) begin   // any load stops the run
            running <= RUN_STOPPED;
        end else if (start_pause) begin
            running <= (running == RUN_COUNTING) ? RUN_STOPPED : RUN_COUNTING;
        end
    end

    // read strobe goes either to the time chain or to the alarm slots
    always_comb begin
        time_load.valid = read_para && !alarm_mode;
        time_load.field = para_select;
        time_load.value = (mode == MODE_STOPWATCH) ? 8'h00 : data_bcd;   // stopwatch clears

        alarm_wr.valid = read_para && alarm_mode;
        alarm_wr.slot  = alarm_no;
        alarm_wr.field = para_select;
        alarm_wr.value = data_bcd;
    end

endmodule

// File: src/time_chain.sv
`timescale 1ns/1ns
`include "timer_consts.svh"

module time_chain (
    input  logic                   clk_100Hz,
    input  logic                   rst,
    input  timer_pkg::timer_mode_e mode,
    input  timer_pkg::run_state_e  running,
    input  timer_pkg::time_load_t  time_load,
    output timer_pkg::time_t       cur_time,
    output logic                   min_carry
);
    import timer_pkg::*;

    logic [3:0] field_load;
    logic       count_down;
    logic       csec_en;
    logic       csec_carry;
    logic       sec_carry;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            field_load[i] = time_load.valid && (time_load.field == field_sel_t'(i));
        end
    end

    assign count_down = (mode == MODE_COUNTDOWN);
    assign csec_en    = (running == RUN_COUNTING);

    bcd_counter #(.TOP_VALUE(`CSEC_LIMIT)) u_csec (
        .clk_100Hz  (clk_100Hz),
        .rst        (rst),
        .load       (field_load[0]),
        .load_value (time_load.value),
        .en         (csec_en),
        .count_down (count_down),
        .value      (cur_time.csec),
        .carry      (csec_carry)
    );

    bcd_counter #(.TOP_VALUE(`SEC_LIMIT)) u_sec (
        .clk_100Hz  (clk_100Hz),
        .rst        (rst),
        .load       (field_load[1]),
        .load_value (time_load.value),
        .en         (csec_carry),
        .count_down (count_down),
        .value      (cur_time.sec),
        .carry      (sec_carry)
    );

    bcd_counter #(.TOP_VALUE(`MIN_LIMIT)) u_min (
        .clk_100Hz  (clk_100Hz),
        .rst        (rst),
        .load       (field_load[2]),
        .load_value (time_load.value),
        .en         (sec_carry),
        .count_down (count_down),
        .value      (cur_time.min),
        .carry      (min_carry)   // also drives the hour chime
    );

    bcd_counter #(.TOP_VALUE(`HOUR_LIMIT)) u_hour (
        .clk_100Hz  (clk_100Hz),
        .rst        (rst),
        .load       (field_load[3]),
        .load_value (time_load.value),
        .en         (min_carry),
        .count_down (count_down),
        .value      (cur_time.hour),
        .carry      ()   // day rollover has no consumer
    );

endmodule

// File: src/event_flags.sv
`timescale 1ns/1ns
`include "timer_consts.svh"

module event_flags (
    input  logic                           clk_100Hz,
    input  logic                           rst,
    input  timer_pkg::timer_mode_e         mode,
    input  timer_pkg::time_t               cur_time,
    input  logic [`TIMER_NUM_ALARMS-1:0]   alarm_match,
    input  logic                           min_carry,
    output logic                           alarm_hit,
    output logic                           hour_chime,
    output logic                           countdown_done
);
    import timer_pkg::*;

    logic clock_mode;
    logic at_zero;

    assign clock_mode = (mode == MODE_CLOCK);
    assign at_zero    = (cur_time == '0);

    always_ff @(posedge clk_100Hz) begin
        if (rst) begin
            alarm_hit      <= 1'b0;
            hour_chime     <= 1'b0;
            countdown_done <= 1'b0;
        end else begin
            alarm_hit      <= clock_mode && (|alarm_match);
            hour_chime     <= clock_mode && min_carry;   // minute wrap = full hour
            countdown_done <= (mode == MODE_COUNTDOWN) && at_zero;
        end
    end

endmodule

// File: src/timer_top.sv
`timescale 1ns/1ns
`include "timer_consts.svh"

module timer_top (
    input  logic                   clk_100Hz,
    input  logic                   rst,
    input  logic                   start_pause,
    input  logic                   read_para,
    input  timer_pkg::timer_mode_e mode,
    input  timer_pkg::field_sel_t  para_select,
    input  timer_pkg::alarm_idx_t  alarm_no,
    input  timer_pkg::bcd_pair_t   data_bcd,
    output timer_pkg::time_t       cur_time,
    output logic                   alarm_hit,
    output logic                   hour_chime,
    output logic                   countdown_done
);
    import timer_pkg::*;

    run_state_e                   running;
    time_load_t                   time_load;
    alarm_wr_t                    alarm_wr;
    logic                         min_carry;
    logic [`TIMER_NUM_ALARMS-1:0] alarm_match;

    setup_control u_setup (
        .clk_100Hz   (clk_100Hz),
        .rst         (rst),
        .start_pause (start_pause),
        .read_para   (read_para),
        .mode        (mode),
        .para_select (para_select),
        .alarm_no    (alarm_no),
        .data_bcd    (data_bcd),
        .running     (running),
        .time_load   (time_load),
        .alarm_wr    (alarm_wr)
    );

    time_chain u_chain (
        .clk_100Hz (clk_100Hz),
        .rst       (rst),
        .mode      (mode),
        .running   (running),
        .time_load (time_load),
        .cur_time  (cur_time),
        .min_carry (min_carry)
    );

    genvar i;
    generate
        for (i = 0; i < `TIMER_NUM_ALARMS; i++) begin : g_slot
            alarm_slot #(.SLOT_INDEX(alarm_idx_t'(i))) u_slot (
                .clk_100Hz (clk_100Hz),
                .rst       (rst),
                .alarm_wr  (alarm_wr),
                .cur_time  (cur_time),
                .match     (alarm_match[i])
            );
        end
    endgenerate

    event_flags u_flags (
        .clk_100Hz      (clk_100Hz),
        .rst            (rst),
        .mode           (mode),
        .cur_time       (cur_time),
        .alarm_match    (alarm_match),
        .min_carry      (min_carry),
        .alarm_hit      (alarm_hit),
        .hour_chime     (hour_chime),
        .countdown_done (countdown_done)
    );

endmodule

// File: verif/timer_props.sv
`timescale 1ns/1ns
`include "timer_consts.svh"

module timer_props (
    input logic                   clk_100Hz,
    input logic                   rst,
    input timer_pkg::timer_mode_e mode,
    input timer_pkg::time_t       cur_time,
    input logic                   alarm_hit,
    input logic                   hour_chime,
    input logic                   countdown_done
);
    import timer_pkg::*;

    function automatic logic field_ok(bcd_pair_t v, bcd_pair_t top);
        return (v[3:0] <= 4'd9) && (v[7:4] <= 4'd9) && (v <= top);
    endfunction

    assert property (@(posedge clk_100Hz) disable iff (rst)
        field_ok(cur_time.csec, `CSEC_LIMIT) && field_ok(cur_time.sec, `SEC_LIMIT)
        && field_ok(cur_time.min, `MIN_LIMIT) && field_ok(cur_time.hour, `HOUR_LIMIT))
        else $error("cur_time field out of range or not bcd");

    // run already stopped by the previous alarm-set cycle
    assert property (@(posedge clk_100Hz) disable iff (rst)
        (mode == MODE_ALARM_SET && $past(mode) == MODE_ALARM_SET) |=> $stable(cur_time))
        else $error("cur_time moved in alarm set mode");

    assert property (@(posedge clk_100Hz) disable iff (rst)
        countdown_done |-> $past(mode) == MODE_COUNTDOWN)
        else $error("countdown_done outside countdown mode");

    assert property (@(posedge clk_100Hz) disable iff (rst)
        (alarm_hit || hour_chime) |-> $past(mode) == MODE_CLOCK)
        else $error("clock event outside clock mode");

endmodule

bind timer_top timer_props u_props (
    .clk_100Hz      (clk_100Hz),
    .rst            (rst),
    .mode           (mode),
    .cur_time       (cur_time),
    .alarm_hit      (alarm_hit),
    .hour_chime     (hour_chime),
    .countdown_done (countdown_done)
);

// File: verif/tb_timer.sv
`timescale 1ns/1ns
`include "timer_consts.svh"

module tb_timer;
    import timer_pkg::*;

    localparam int RUN_LEN      = 200;   // random cycles per counting test
    localparam int TOTAL_CYCLES = 36 + 121 + 3 * RUN_LEN + 116;   // fixed steps plus random runs
    localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * 10;

    logic        clk_100Hz = 1'b0;
    logic        rst, start_pause, read_para;
    timer_mode_e mode;
    field_sel_t  para_select;
    alarm_idx_t  alarm_no;
    bcd_pair_t   data_bcd;
    time_t       cur_time;
    logic        alarm_hit, hour_chime, countdown_done;

    int          seed, err_count, check_count, test_errs, hit_count;
    logic        m_run, m_hit, m_chime, m_done;   // reference model state
    time_t       m_time;
    time_t       m_alarm [`TIMER_NUM_ALARMS];
    logic        m_armed [`TIMER_NUM_ALARMS];

    timer_top i_dut (.*);

    always #5 clk_100Hz = ~clk_100Hz;

    function automatic int to_int(bcd_pair_t b);
        return int'(b[7:4]) * 10 + int'(b[3:0]);
    endfunction

    function automatic bcd_pair_t to_bcd(int n);
        return {4'(n / 10), 4'(n % 10)};
    endfunction

    function automatic int top_of(int f);   // 0 csec .. 3 hour
        return to_int(f == 0 ? `CSEC_LIMIT : f == 1 ? `SEC_LIMIT :
                      f == 2 ? `MIN_LIMIT : `HOUR_LIMIT);
    endfunction

    function automatic bcd_pair_t next_val(bcd_pair_t v, int f, logic down);
        int n;
        n = to_int(v);
        return to_bcd(down ? (n == 0 ? top_of(f) : n - 1) : (n == top_of(f) ? 0 : n + 1));
    endfunction

    function automatic logic wraps(bcd_pair_t v, int f, logic down);
        return down ? (to_int(v) == 0) : (to_int(v) == top_of(f));
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic time_t rand_time();
        time_t t;
        for (int f = 0; f < 4; f++)
            t[f*8 +: 8] = to_bcd(rand_below(top_of(f) + 1));
        return t;
    endfunction

    // time reached after k upward steps
    function automatic time_t time_after(time_t t, int k);
        logic c;
        repeat (k) begin
            c = 1'b1;
            for (int f = 0; f < 4; f++) begin
                if (c) begin
                    c = wraps(t[f*8 +: 8], f, 1'b0);
                    t[f*8 +: 8] = next_val(t[f*8 +: 8], f, 1'b0);
                end
            end
        end
        return t;
    endfunction

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one rising edge of the model, from the inputs now applied
    task automatic model_edge();
        logic       down;
        logic [4:0] en;   // en[f] steps field f
        logic       any_match;
        time_t      nxt;
        down      = (mode == MODE_COUNTDOWN);
        en[0]     = m_run;
        any_match = 1'b0;
        nxt       = m_time;
        for (int f = 0; f < 4; f++) begin
            en[f + 1] = en[f] && wraps(m_time[f*8 +: 8], f, down);
            if (read_para && mode != MODE_ALARM_SET && int'(para_select) == f)
                nxt[f*8 +: 8] = (mode == MODE_STOPWATCH) ? 8'h00 : data_bcd;
            else if (en[f])
                nxt[f*8 +: 8] = next_val(m_time[f*8 +: 8], f, down);
        end
        for (int s = 0; s < `TIMER_NUM_ALARMS; s++)
            any_match = any_match | (m_armed[s] && m_alarm[s] == m_time);
        m_hit   = (mode == MODE_CLOCK) && any_match;
        m_chime = (mode == MODE_CLOCK) && en[3];   // minute carry
        m_done  = (mode == MODE_COUNTDOWN) && (m_time == '0);
        if (read_para && mode == MODE_ALARM_SET) begin
            m_armed[alarm_no] = 1'b1;
            m_alarm[alarm_no][int'(para_select)*8 +: 8] = data_bcd;
        end
        if (read_para || mode == MODE_ALARM_SET)
            m_run = 1'b0;
        else if (start_pause)
            m_run = !m_run;
        m_time = nxt;
    endtask

    task automatic tick();
        model_edge();
        @(posedge clk_100Hz);
        @(negedge clk_100Hz);
        check_value("cur_time", cur_time, m_time);
        check_value("alarm_hit", 32'(alarm_hit), 32'(m_hit));
        check_value("hour_chime", 32'(hour_chime), 32'(m_chime));
        check_value("countdown_done", 32'(countdown_done), 32'(m_done));
        hit_count  += int'(alarm_hit);
        start_pause = 1'b0;   // strobes last one cycle
        read_para   = 1'b0;
    endtask

    task automatic load_field(timer_mode_e md, int f, bcd_pair_t v);
        mode        = md;
        para_select = field_sel_t'(f);
        data_bcd    = v;
        read_para   = 1'b1;
        tick();
    endtask

    task automatic load_time(timer_mode_e md, time_t t);
        for (int f = 3; f >= 0; f--)
            load_field(md, f, t[f*8 +: 8]);
    endtask

    task automatic toggle_run(timer_mode_e md);
        mode        = md;
        start_pause = 1'b1;
        tick();
    endtask

    task automatic write_alarm(int s, time_t t);
        alarm_no = alarm_idx_t'(s);
        for (int f = 0; f < 4; f++)
            load_field(MODE_ALARM_SET, f, t[f*8 +: 8]);
    endtask

    // random pauses and field loads while counting
    task automatic random_run(timer_mode_e md, int cycles);
        int r;
        repeat (cycles) begin
            r = rand_below(100);
            if (r < 3) begin
                start_pause = 1'b1;
            end else if (r < 5) begin
                para_select = field_sel_t'(rand_below(4));
                data_bcd    = to_bcd(rand_below(top_of(int'(para_select)) + 1));
                if (md == MODE_STOPWATCH)
                    data_bcd = 8'($random(seed));   // any value, cleared anyway
                read_para   = 1'b1;
            end else if (r < 12 && !m_run) begin
                start_pause = 1'b1;   // restart soon after a load
            end
            mode = md;
            tick();
        end
    endtask

    task automatic end_test(string name);
        $display("%-10s : %0d mismatches", name, err_count - test_errs);
        test_errs = err_count;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed        = 32'h9425d9e9;
        rst         = 1'b1;
        start_pause = 1'b0;
        read_para   = 1'b0;
        mode        = MODE_CLOCK;
        para_select = '0;
        alarm_no    = '0;
        data_bcd    = '0;
        m_run       = 1'b0;
        m_time      = '0;
        for (int s = 0; s < `TIMER_NUM_ALARMS; s++) begin
            m_armed[s] = 1'b0;
            m_alarm[s] = '0;
        end
        repeat (16) @(posedge clk_100Hz);
        @(negedge clk_100Hz);
        rst = 1'b0;

        check_value("time after reset", cur_time, 32'h0);
        check_value("alarm_hit after reset", 32'(alarm_hit), 32'h0);
        check_value("hour_chime after reset", 32'(hour_chime), 32'h0);
        check_value("countdown_done after reset", 32'(countdown_done), 32'h0);
        repeat (20) tick();   // idle at midnight, no slot armed
        end_test("reset");

        load_time(MODE_CLOCK, 32'h23_59_59_95);   // day wrap
        toggle_run(MODE_CLOCK);
        repeat (10) tick();
        load_time(MODE_CLOCK, 32'h07_59_59_97);
        toggle_run(MODE_CLOCK);
        repeat (10) tick();
        random_run(MODE_CLOCK, RUN_LEN);
        end_test("clock");

        load_time(MODE_COUNTDOWN, {24'h0, to_bcd(10 + rand_below(40))});
        toggle_run(MODE_COUNTDOWN);
        repeat (60) tick();   // through zero and the wrap to 23:59:59.99
        load_time(MODE_COUNTDOWN, rand_time());
        toggle_run(MODE_COUNTDOWN);
        random_run(MODE_COUNTDOWN, RUN_LEN);
        end_test("countdown");

        load_time(MODE_CLOCK, rand_time());
        load_field(MODE_STOPWATCH, rand_below(4), 8'($random(seed)));
        toggle_run(MODE_STOPWATCH);
        repeat (10) tick();
        load_time(MODE_STOPWATCH, 32'h12_34_56_78);
        toggle_run(MODE_STOPWATCH);
        random_run(MODE_STOPWATCH, RUN_LEN);
        end_test("stopwatch");

        for (int round = 0; round < 4; round++) begin
            load_time(MODE_CLOCK, rand_time());
            write_alarm(rand_below(`TIMER_NUM_ALARMS), time_after(m_time, 3 + rand_below(8)));
            hit_count = 0;
            toggle_run(round % 2 == 0 ? MODE_CLOCK : MODE_STOPWATCH);
            repeat (20) tick();
            check_value("alarm fired", 32'(hit_count != 0), 32'(round % 2 == 0));
        end
        end_test("alarm");

        $display("checks %0d, mismatches %0d", check_count, err_count);
        if (err_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
src/timer_pkg.sv
src/bcd_counter.sv
src/alarm_slot.sv
src/setup_control.sv
src/time_chain.sv
src/event_flags.sv
src/timer_top.sv
verif/timer_props.sv
verif/tb_timer.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_timer -f filelist.f \
    && ./obj_dir/Vtb_timer > sim.log 2>&1 || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qsx "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
